/* exec_params.svh */
// width and depth macros for the execute stage, included by the datapath package and by modules
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data and address width
`define WORD_W 32

// register file index width, 32 registers
`define REG_W 5

// entries per result fifo, not counting the output head register
// must stay a power of two so the pointers wrap on their own
`define FIFO_DEPTH 4

`endif

/* isa_pkg.sv */
// operation encodings the scoreboard places in an issue and the execute units decode
package isa_pkg;

    // integer alu operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,  // arithmetic, sign fill
        SLT  = 4'd8,  // signed compare
        SLTU = 4'd9   // unsigned compare
    } alu_op_e;

    // branch conditions, the two jumps fill the top of the range
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5,
        JAL  = 3'd6,
        JALR = 3'd7   // target from register a
    } branch_cond_e;

    // word accesses only
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } mem_type_e;

endpackage

/* datapath_pkg.sv */
// packed bundles exchanged between scoreboard, execute units, result buffers, fetch and writeback
`include "exec_params.svh"

package datapath_pkg;
    import isa_pkg::*;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_W-1:0]  reg_idx_t;

    // scoreboard issue, at most one enable set
    typedef struct packed {
        logic         alu_en;
        logic         bfu_en;
        logic         sls_en;
        reg_idx_t     rd;          // destination for alu, jump link and load
        alu_op_e      alu_op;
        word_t        op_a;
        word_t        op_b;
        word_t        pc;          // pc of the issued instruction
        word_t        imm;
        branch_cond_e br_cond;
        logic         pred_taken;  // prediction made by fetch
        mem_type_e    mem_type;
        logic         halt;        // passes straight through
    } issue_t;

    // one register write
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } wb_result_t;

    // resolution sent back to fetch
    typedef struct packed {
        logic  miss;        // outcome differs from prediction
        logic  taken;
        word_t correct_pc;  // redirect address
        logic  update_btb;
    } branch_res_t;

    // data memory request, held until dhit
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store_data;
    } dmem_req_t;

    // per unit done bits for the scoreboard
    typedef struct packed {
        logic alu;
        logic sls;
        logic bfu;
    } fu_done_t;

endpackage

/* fu_alu.sv */
// combinational integer alu, its result goes into the writeback fifo in the issue cycle
`timescale 1ns/100ps

module fu_alu
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  issue_t     issue,
    output logic       push,
    output wb_result_t result
);

    logic [4:0] shamt;    // shift amount
    word_t      alu_out;

    assign shamt = issue.op_b[4:0];  // low 5 bits only
    assign push  = issue.alu_en;     // one cycle, no state

    always_comb begin
        case (issue.alu_op)
            ADD:     alu_out = issue.op_a + issue.op_b;
            SUB:     alu_out = issue.op_a - issue.op_b;
            AND:     alu_out = issue.op_a & issue.op_b;
            OR:      alu_out = issue.op_a | issue.op_b;
            XOR:     alu_out = issue.op_a ^ issue.op_b;
            SLL:     alu_out = issue.op_a << shamt;
            SRL:     alu_out = issue.op_a >> shamt;
            SRA:     alu_out = $signed(issue.op_a) >>> shamt;  // keeps sign bit
            SLT:     alu_out = word_t'($signed(issue.op_a) < $signed(issue.op_b));
            SLTU:    alu_out = word_t'(issue.op_a < issue.op_b);
            default: alu_out = '0;  // unused encodings
        endcase
    end

    // tag with destination
    assign result = '{rd: issue.rd, data: alu_out};

endmodule

/* fu_branch.sv */
// branch and jump resolution, feeds the fetch redirect fifo and the jump link into writeback
`timescale 1ns/100ps

module fu_branch
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  issue_t      issue,
    output logic        br_push,
    output branch_res_t br_res,
    output logic        link_push,
    output wb_result_t  link
);

    logic  taken;
    logic  is_jump;
    word_t target;
    word_t next_pc;   // fall through and link value
    word_t jalr_sum;

    assign is_jump  = (issue.br_cond == JAL) || (issue.br_cond == JALR);
    assign next_pc  = issue.pc + word_t'(4);
    assign jalr_sum = issue.op_a + issue.imm;

    // condition on the two operands
    always_comb begin
        case (issue.br_cond)
            BEQ:     taken = (issue.op_a == issue.op_b);
            BNE:     taken = (issue.op_a != issue.op_b);
            BLT:     taken = ($signed(issue.op_a) < $signed(issue.op_b));
            BGE:     taken = ($signed(issue.op_a) >= $signed(issue.op_b));
            BLTU:    taken = (issue.op_a < issue.op_b);
            BGEU:    taken = (issue.op_a >= issue.op_b);
            default: taken = 1'b1;  // JAL, JALR
        endcase
    end

    // jalr is register relative, bit 0 cleared
    assign target = (issue.br_cond == JALR) ? (jalr_sum & ~word_t'(1)) : issue.pc + issue.imm;

    assign br_push = issue.bfu_en;
    assign br_res  = '{
        miss:       (taken != issue.pred_taken),
        taken:      taken,
        correct_pc: taken ? target : next_pc,
        update_btb: taken
    };

    // jumps also write the return address
    assign link_push = issue.bfu_en && is_jump;
    assign link      = '{rd: issue.rd, data: next_pc};

endmodule

/* fu_scalar_ls.sv */
// word load/store unit with one access in flight, talks to the data memory over a dhit handshake
`timescale 1ns/100ps
`include "exec_params.svh"

module fu_scalar_ls
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,
    input  issue_t             issue,
    output dmem_req_t          dmem_req,
    input  logic               dmem_dhit,
    input  logic [`WORD_W-1:0] dmem_load,
    output logic               ld_valid,
    output wb_result_t         ld_res,
    input  logic               ld_ready,
    output logic               busy,
    output logic               done
);

    typedef enum logic [1:0] {IDLE, ACCESS, HOLD} state_e;

    state_e   state;
    state_e   state_n;
    logic     start;     // accepted issue
    logic     hit;       // memory answered this cycle
    logic     ren_q;
    logic     wen_q;
    word_t    addr_q;
    word_t    store_q;
    reg_idx_t rd_q;
    word_t    ld_data_q;

    assign start = (state == IDLE) && issue.sls_en;
    assign hit   = (state == ACCESS) && dmem_dhit;

    always_comb begin
        state_n = state;
        case (state)
            IDLE:    if (issue.sls_en) state_n = ACCESS;
            ACCESS:  if (dmem_dhit) state_n = wen_q ? IDLE : HOLD;  // stores finish on dhit
            HOLD:    if (ld_ready) state_n = IDLE;                  // arbiter took the load
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            state <= state_n;
            if (start) begin
                ren_q <= (issue.mem_type == LOAD);
                wen_q <= (issue.mem_type == STORE);
            end else if (hit) begin
                ren_q <= 1'b0;  // drop request after dhit
                wen_q <= 1'b0;
            end
        end
    end

    // address, data and tag
    always_ff @(posedge CLK) begin
        if (start) begin
            addr_q  <= issue.op_a + issue.imm;
            store_q <= issue.op_b;
            rd_q    <= issue.rd;
        end
        if (hit && ren_q)
            ld_data_q <= dmem_load;
    end

    assign dmem_req = '{ren: ren_q, wen: wen_q, addr: addr_q, store_data: store_q};
    assign ld_valid = (state == HOLD);
    assign ld_res   = '{rd: rd_q, data: ld_data_q};
    assign busy     = (state != IDLE);
    assign done     = (hit && wen_q) || (ld_valid && ld_ready);

endmodule

/* result_fifo.sv */
// synchronous fifo with registered head and valid/ready on both sides, payload type set per instance
`timescale 1ns/100ps
`include "exec_params.svh"

module result_fifo
    import datapath_pkg::*;
#(
    parameter type T = wb_result_t
) (
    input  logic CLK,
    input  logic rst,
    input  logic push,
    input  T     din,
    output logic full,
    output logic valid,
    output T     dout,
    input  logic ready
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;      // entries in mem, head not counted
    logic             head_load;  // head empty or popped this cycle
    logic             from_mem;
    logic             bypass;     // empty fifo, push goes straight to head
    logic             to_mem;

    assign head_load = !valid || ready;
    assign from_mem  = head_load && (count != '0);
    assign bypass    = head_load && (count == '0) && push;
    assign to_mem    = push && !bypass;
    assign full      = (count == (PTR_W + 1)'(DEPTH));

    always_ff @(posedge CLK) begin
        if (rst) begin
            valid  <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (head_load)
                valid <= from_mem || bypass;
            if (to_mem)
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (from_mem)
                rd_ptr <= rd_ptr + 1'b1;
            case ({to_mem, from_mem})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (to_mem)
            mem[wr_ptr] <= din;
        if (from_mem)
            dout <= mem[rd_ptr];  // oldest first
        else if (bypass)
            dout <= din;
    end

endmodule

/* wb_arbiter.sv */
// registered writeback stage, merges the held load result with the alu/jump fifo head
`timescale 1ns/100ps

module wb_arbiter
    import datapath_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       ld_valid,
    input  wb_result_t ld_res,
    output logic       ld_ready,
    input  logic       fifo_valid,
    input  wb_result_t fifo_res,
    output logic       fifo_ready,
    output logic       wb_valid,
    output wb_result_t wb_out,
    input  logic       wb_ready
);

    logic take;  // output register free or draining

    assign take       = !wb_valid || wb_ready;
    assign ld_ready   = take;
    assign fifo_ready = take && !ld_valid;  // load wins

    always_ff @(posedge CLK) begin
        if (rst)
            wb_valid <= 1'b0;
        else if (take)
            wb_valid <= ld_valid || fifo_valid;
    end

    // held while wb_ready is low
    always_ff @(posedge CLK) begin
        if (take) begin
            if (ld_valid)
                wb_out <= ld_res;
            else if (fifo_valid)
                wb_out <= fifo_res;
        end
    end

endmodule

/* execute.sv */
// execute stage top, wires the units, result fifos and writeback arbiter to scoreboard and memory
`timescale 1ns/100ps
`include "exec_params.svh"

module execute
    import datapath_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,
    input  issue_t             issue,
    output logic               issue_ready,
    output dmem_req_t          dmem_req,
    input  logic               dmem_dhit,
    input  logic [`WORD_W-1:0] dmem_load,
    output logic               wb_valid,
    output wb_result_t         wb_out,
    input  logic               wb_ready,
    output logic               br_valid,
    output branch_res_t        br_out,
    input  logic               br_ready,
    output fu_done_t           fu_done,
    output logic               halt_out
);

    logic        alu_push;
    wb_result_t  alu_res;
    logic        br_push;
    branch_res_t br_res;
    logic        link_push;
    wb_result_t  link_res;
    logic        ld_valid;
    wb_result_t  ld_res;
    logic        ld_ready;
    logic        sls_busy;
    logic        sls_done;
    logic        wb_push;
    wb_result_t  wb_din;
    logic        wb_full;
    logic        fifo_valid;
    wb_result_t  fifo_res;
    logic        fifo_ready;
    logic        br_full;

    fu_alu alu_i (.issue(issue), .push(alu_push), .result(alu_res));

    fu_branch bfu_i (
        .issue(issue), .br_push(br_push), .br_res(br_res),
        .link_push(link_push), .link(link_res)
    );

    fu_scalar_ls sls_i (
        .CLK(CLK), .rst(rst), .issue(issue),
        .dmem_req(dmem_req), .dmem_dhit(dmem_dhit), .dmem_load(dmem_load),
        .ld_valid(ld_valid), .ld_res(ld_res), .ld_ready(ld_ready),
        .busy(sls_busy), .done(sls_done)
    );

    // one enable per cycle, so alu and jump link never collide
    assign wb_push = alu_push || link_push;
    assign wb_din  = alu_push ? alu_res : link_res;

    result_fifo #(.T(wb_result_t)) wb_fifo_i (
        .CLK(CLK), .rst(rst), .push(wb_push), .din(wb_din), .full(wb_full),
        .valid(fifo_valid), .dout(fifo_res), .ready(fifo_ready)
    );

    result_fifo #(.T(branch_res_t)) br_fifo_i (
        .CLK(CLK), .rst(rst), .push(br_push), .din(br_res), .full(br_full),
        .valid(br_valid), .dout(br_out), .ready(br_ready)  // straight to fetch
    );

    wb_arbiter arb_i (
        .CLK(CLK), .rst(rst),
        .ld_valid(ld_valid), .ld_res(ld_res), .ld_ready(ld_ready),
        .fifo_valid(fifo_valid), .fifo_res(fifo_res), .fifo_ready(fifo_ready),
        .wb_valid(wb_valid), .wb_out(wb_out), .wb_ready(wb_ready)
    );

    assign issue_ready = !sls_busy && !wb_full && !br_full;
    assign fu_done     = '{alu: alu_push, sls: sls_done, bfu: br_push};
    assign halt_out    = issue.halt;  // to the scoreboard, no speculation tracking here

endmodule

/* execute_chk.sv */
// concurrent checks on issue legality and output handshakes, bound into the execute top
`timescale 1ns/100ps

module execute_chk
    import datapath_pkg::*;
(
    input logic        CLK,
    input logic        rst,
    input issue_t      issue,
    input logic        issue_ready,
    input dmem_req_t   dmem_req,
    input logic        dmem_dhit,
    input logic        wb_valid,
    input wb_result_t  wb_out,
    input logic        wb_ready,
    input logic        br_valid,
    input branch_res_t br_out,
    input logic        br_ready
);

    logic any_en;             // some unit enabled this cycle
    int   assert_errors = 0;  // failed assertions so far

    assign any_en = issue.alu_en || issue.bfu_en || issue.sls_en;

    one_enable: assert property (@(posedge CLK) disable iff (rst)
        $onehot0({issue.alu_en, issue.bfu_en, issue.sls_en}))
        else begin
            assert_errors++;
            $error("more than one unit enabled in one issue");
        end

    issue_when_ready: assert property (@(posedge CLK) disable iff (rst) any_en |-> issue_ready)
        else begin
            assert_errors++;
            $error("issue while issue_ready low");
        end

    // stalled heads hold their value
    wb_hold: assert property (@(posedge CLK) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_out))
        else begin
            assert_errors++;
            $error("wb_out changed while stalled");
        end

    br_hold: assert property (@(posedge CLK) disable iff (rst)
        br_valid && !br_ready |=> br_valid && $stable(br_out))
        else begin
            assert_errors++;
            $error("br_out changed while stalled");
        end

    req_hold: assert property (@(posedge CLK) disable iff (rst)
        (dmem_req.ren || dmem_req.wen) && !dmem_dhit |=> $stable(dmem_req))
        else begin
            assert_errors++;
            $error("dmem_req changed before dhit");
        end

endmodule

bind execute execute_chk chk_i (
    .CLK(CLK), .rst(rst), .issue(issue), .issue_ready(issue_ready),
    .dmem_req(dmem_req), .dmem_dhit(dmem_dhit),
    .wb_valid(wb_valid), .wb_out(wb_out), .wb_ready(wb_ready),
    .br_valid(br_valid), .br_out(br_out), .br_ready(br_ready)
);

/* execute_tb.sv */
// testbench for the execute stage, random issue stream against a reference model and memory responder
`timescale 1ns/100ps

module execute_tb
    import isa_pkg::*;
    import datapath_pkg::*;
();

    localparam int NUM_ISSUES      = 400;
    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = NUM_ISSUES * 40;

    logic        CLK;
    logic        rst;
    issue_t      issue;
    logic        issue_ready;
    dmem_req_t   dmem_req;
    logic        dmem_dhit;
    word_t       dmem_load;
    logic        wb_valid;
    wb_result_t  wb_out;
    logic        wb_ready;
    logic        br_valid;
    branch_res_t br_out;
    logic        br_ready;
    fu_done_t    fu_done;
    logic        halt_out;

    wb_result_t  wb_exp[$];          // alu and jump links, issue order
    wb_result_t  ld_exp[$];          // never more than one load pending
    branch_res_t br_exp[$];
    dmem_req_t   req_exp[$];
    word_t       model_mem[word_t];  // reference view, written at issue
    word_t       resp_mem[word_t];   // responder view, written on dhit
    int          wb_errors;
    int          br_errors;
    int          req_errors;
    int          flag_errors;
    int          protocol_errors;
    int          issued;
    logic        serving;            // responder counting down a request
    int          wait_cnt;
    logic        sls_active;         // access issued, done not seen yet
    logic        sls_store;
    logic        ld_wait;            // load data back, waiting for the arbiter
    logic        sls_done_exp;

    execute dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // unwritten words, every address bit matters
    function automatic word_t fill_word(word_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr << 7) ^ 32'h6b3d_c2a5;
    endfunction

    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        logic [4:0]  sh;
        logic [63:0] ext;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;  // sign extended then shifted
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return ext[31:0];
            SLT:     return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            SLTU:    return word_t'(a < b);
            default: return '0;
        endcase
    endfunction

    function automatic logic cond_taken(branch_cond_e c, word_t a, word_t b);
        logic lt;
        lt = (a[31] != b[31]) ? a[31] : (a < b);  // signed less than
        case (c)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return lt;
            BGE:     return !lt;
            BLTU:    return a < b;
            BGEU:    return !(a < b);
            default: return 1'b1;  // jumps
        endcase
    endfunction

    function automatic branch_res_t branch_model(issue_t i);
        branch_res_t r;
        word_t       tgt;
        r.taken      = cond_taken(i.br_cond, i.op_a, i.op_b);
        tgt          = (i.br_cond == JALR) ? ((i.op_a + i.imm) & 32'hffff_fffe) : (i.pc + i.imm);
        r.miss       = r.taken ^ i.pred_taken;
        r.correct_pc = r.taken ? tgt : i.pc + 32'd4;
        r.update_btb = r.taken;
        return r;
    endfunction

    task automatic check_wb(string name, wb_result_t got, wb_result_t exp);
        if (got !== exp) begin
            wb_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_br(string name, branch_res_t got, branch_res_t exp);
        if (got !== exp) begin
            br_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_req(string name, dmem_req_t got, dmem_req_t exp);
        if (got !== exp) begin
            req_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic make_issue(output issue_t i);
        int kind;
        i          = '0;
        kind       = $urandom_range(0, 9);
        i.halt     = ($urandom_range(0, 15) == 0);
        i.rd       = reg_idx_t'($urandom);
        i.op_a     = $urandom;
        i.op_b     = ($urandom_range(0, 3) == 0) ? i.op_a : $urandom;  // equal operands now and then
        i.pc       = $urandom & 32'hffff_fffc;
        i.imm      = word_t'($urandom_range(0, 255)) - 32'd128;
        if (kind < 4) begin
            i.alu_en = 1'b1;
            i.alu_op = alu_op_e'($urandom_range(0, 9));
        end else if (kind < 7) begin
            i.bfu_en     = 1'b1;
            i.br_cond    = branch_cond_e'($urandom_range(0, 7));
            i.pred_taken = 1'($urandom_range(0, 1));
        end else begin
            i.sls_en   = 1'b1;
            i.mem_type = mem_type_e'($urandom_range(0, 1));
            i.op_a     = 32'h0000_1000 + 4 * $urandom_range(0, 15);  // small window so loads hit stores
            i.imm      = 4 * $urandom_range(0, 7);
        end
    endtask

    task automatic record_issue(issue_t i);
        word_t addr;
        addr = i.op_a + i.imm;
        if (i.alu_en)
            wb_exp.push_back(wb_result_t'{rd: i.rd, data: alu_model(i.alu_op, i.op_a, i.op_b)});
        if (i.bfu_en) begin
            br_exp.push_back(branch_model(i));
            if (i.br_cond == JAL || i.br_cond == JALR)
                wb_exp.push_back(wb_result_t'{rd: i.rd, data: i.pc + 32'd4});  // link
        end
        if (i.sls_en && i.mem_type == STORE) begin
            model_mem[addr] = i.op_b;
            req_exp.push_back(dmem_req_t'{ren: 1'b0, wen: 1'b1, addr: addr, store_data: i.op_b});
        end else if (i.sls_en) begin
            ld_exp.push_back(wb_result_t'{rd: i.rd,
                data: model_mem.exists(addr) ? model_mem[addr] : fill_word(addr)});
            req_exp.push_back(dmem_req_t'{ren: 1'b1, wen: 1'b0, addr: addr, store_data: '0});
        end
    endtask

    // memory side, random wait of 0 to 5 cycles per request
    task automatic serve_mem();
        dmem_req_t got;
        dmem_dhit = 1'b0;
        dmem_load = $urandom;  // junk unless dhit
        got       = dmem_req;
        if (got.ren || got.wen) begin
            if (!serving) begin
                serving  = 1'b1;
                wait_cnt = $urandom_range(0, 5);
                if (got.ren)
                    got.store_data = '0;  // unused on loads
                if (req_exp.size() == 0) begin
                    protocol_errors++;
                    $display("memory request with no access pending at %0t", $time);
                end else
                    check_req("dmem_req", got, req_exp.pop_front());
            end
            if (wait_cnt == 0) begin
                dmem_dhit = 1'b1;
                serving   = 1'b0;
                if (dmem_req.wen)
                    resp_mem[dmem_req.addr] = dmem_req.store_data;
                else if (resp_mem.exists(dmem_req.addr))
                    dmem_load = resp_mem[dmem_req.addr];
                else
                    dmem_load = fill_word(dmem_req.addr);
            end else
                wait_cnt--;
        end
    endtask

    // one cycle of stimulus, entered 1 ns after the rising edge
    task automatic step(input logic allow_issue);
        issue_t nxt;
        wb_ready = ($urandom_range(0, 3) != 0);
        br_ready = ($urandom_range(0, 3) != 0);
        serve_mem();
        nxt      = '0;
        nxt.halt = ($urandom_range(0, 15) == 0);
        if (allow_issue && issue_ready && $urandom_range(0, 3) != 0) begin
            make_issue(nxt);
            record_issue(nxt);
            issued++;
        end
        issue = nxt;
        @(posedge CLK);
        #1;
    endtask

    // a load may overtake older fifo entries, so it is matched first
    task automatic take_wb();
        if (ld_exp.size() > 0 && wb_out === ld_exp[0])
            void'(ld_exp.pop_front());
        else if (wb_exp.size() > 0)
            check_wb("wb_out", wb_out, wb_exp.pop_front());
        else if (ld_exp.size() > 0)
            check_wb("wb_out", wb_out, ld_exp.pop_front());
        else begin
            protocol_errors++;
            $display("writeback transfer with no result expected at %0t", $time);
        end
    endtask

    // outputs sampled mid cycle
    always @(negedge CLK) begin
        if (!rst) begin
            if (wb_valid && wb_ready)
                take_wb();
            if (br_valid && br_ready && br_exp.size() == 0) begin
                protocol_errors++;
                $display("branch transfer with no resolution expected at %0t", $time);
            end else if (br_valid && br_ready)
                check_br("br_out", br_out, br_exp.pop_front());
            check_bit("halt_out", halt_out, issue.halt);
            check_bit("fu_done.alu", fu_done.alu, issue.alu_en);  // pulses in issue cycle
            check_bit("fu_done.bfu", fu_done.bfu, issue.bfu_en);
            // store done on dhit, load done when the arbiter takes it
            sls_done_exp = (sls_active && sls_store && dmem_dhit)
                        || (ld_wait && (!wb_valid || wb_ready));
            check_bit("fu_done.sls", fu_done.sls, sls_done_exp);
            if (sls_active)
                check_bit("issue_ready", issue_ready, 1'b0);  // unit busy
            if (sls_active && !sls_store && dmem_dhit)
                ld_wait = 1'b1;
            else if (sls_done_exp) begin
                sls_active = 1'b0;
                ld_wait    = 1'b0;
            end
            if (issue.sls_en) begin
                sls_active = 1'b1;
                sls_store  = (issue.mem_type == STORE);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with results still pending", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h8ed1));
        rst             = 1'b1;
        issue           = '0;
        dmem_dhit       = 1'b0;
        dmem_load       = '0;
        wb_ready        = 1'b0;
        br_ready        = 1'b0;
        serving         = 1'b0;
        wait_cnt        = 0;
        sls_active      = 1'b0;
        sls_store       = 1'b0;
        ld_wait         = 1'b0;
        sls_done_exp    = 1'b0;
        issued          = 0;
        wb_errors       = 0;
        br_errors       = 0;
        req_errors      = 0;
        flag_errors     = 0;
        protocol_errors = 0;
        repeat (7) @(posedge CLK);
        @(negedge CLK);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("br_valid", br_valid, 1'b0);
        check_bit("dmem_req.ren", dmem_req.ren, 1'b0);
        check_bit("dmem_req.wen", dmem_req.wen, 1'b0);
        check_bit("issue_ready", issue_ready, 1'b1);
        check_bit("fu_done", |fu_done, 1'b0);
        check_bit("halt_out", halt_out, 1'b0);
        @(posedge CLK);
        #1 rst = 1'b0;  // eighth edge done
        while (issued < NUM_ISSUES)
            step(1'b1);
        while (wb_exp.size() + ld_exp.size() + br_exp.size() + req_exp.size() != 0)
            step(1'b0);
        repeat (10) step(1'b0);  // catch extra outputs
        $display("error counts: wb %0d, br %0d, req %0d, flag %0d, protocol %0d, assert %0d",
                 wb_errors, br_errors, req_errors, flag_errors, protocol_errors,
                 dut_i.chk_i.assert_errors);
        if (wb_errors + br_errors + req_errors + flag_errors + protocol_errors
                + dut_i.chk_i.assert_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
isa_pkg.sv
datapath_pkg.sv
fu_alu.sv
fu_branch.sv
fu_scalar_ls.sv
result_fifo.sv
wb_arbiter.sv
execute.sv
execute_chk.sv
execute_tb.sv

/* Bender.yml */
package:
  name: execute_stage

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - datapath_pkg.sv
  - fu_alu.sv
  - fu_branch.sv
  - fu_scalar_ls.sv
  - result_fifo.sv
  - wb_arbiter.sv
  - execute.sv
  - target: test
    files:
      - execute_chk.sv
      - execute_tb.sv
